// ==== source/aes_ctrl_pkg.sv ====
`default_nettype none

package aes_ctrl_pkg;

	// ============================================================
	// Widths
	// ============================================================
	localparam int BLOCK_W         = 128;
	localparam int WORD_W          = 32;
	localparam int WORDS_PER_BLOCK = BLOCK_W / WORD_W;
	localparam int KEY_W           = 128;

	// Cipher round shape
	localparam int ROT_BITS = 13;
	// Round key r is the key rotated left by RK_STEP * r
	localparam int RK_STEP  = 8;

	// ============================================================
	// Command word fields
	// ============================================================
	localparam int CMD_DECRYPT_BIT = 0;
	localparam int CMD_CBC_BIT     = 1;

	// One FIFO block seen either as payload or as a command
	typedef union packed {
		logic [BLOCK_W-1:0] data;
		struct packed {
			logic [BLOCK_W-WORD_W-1:0] rsvd;
			logic [WORD_W-1:0]         word;
		} cmd;
	} ctrl_block_u;

endpackage

`default_nettype wire

// ==== source/input_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_stage #(
	parameter int IN_FIFO_DEPTH = 4
) (
	input  wire                                   clk,
	input  wire                                   reset,
	input  wire [aes_ctrl_pkg::WORD_W-1:0]        bus_data,
	input  wire                                   bus_data_wren,
	input  wire                                   bus_tlast,
	output logic                                  busy,
	output aes_ctrl_pkg::ctrl_block_u             in_blk,
	output logic                                  in_last,
	output logic                                  in_valid,
	input  wire                                   in_pop
);

	localparam int WC_W = $clog2(aes_ctrl_pkg::WORDS_PER_BLOCK);
	localparam int AW   = (IN_FIFO_DEPTH > 1) ? $clog2(IN_FIFO_DEPTH) : 1;
	localparam int CW   = $clog2(IN_FIFO_DEPTH + 1);
	localparam int ASM_W = aes_ctrl_pkg::BLOCK_W - aes_ctrl_pkg::WORD_W;

	logic [WC_W-1:0]              word_cnt;
	logic [ASM_W-1:0]             asm_q;
	aes_ctrl_pkg::ctrl_block_u    mem [IN_FIFO_DEPTH];
	logic                         last_mem [IN_FIFO_DEPTH];
	logic [AW-1:0]                wr_ptr;
	logic [AW-1:0]                rd_ptr;
	logic [CW-1:0]                count;
	logic                         word_ok;
	logic                         push;

	// Words offered while full are dropped
	assign word_ok = bus_data_wren && !busy;
	assign push    = word_ok && (word_cnt == WC_W'(aes_ctrl_pkg::WORDS_PER_BLOCK - 1));

	assign busy     = (count == CW'(IN_FIFO_DEPTH));
	assign in_valid = (count != '0);
	assign in_blk   = mem[rd_ptr];
	assign in_last  = last_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			word_cnt <= '0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
		end else begin
			if (word_ok)
				word_cnt <= push ? '0 : word_cnt + 1'b1;
			if (push)
				wr_ptr <= (wr_ptr == AW'(IN_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (in_pop)
				rd_ptr <= (rd_ptr == AW'(IN_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, in_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Earlier words sit in the upper bits so the first word ends up on top
	always_ff @(posedge clk) begin
		if (word_ok)
			asm_q <= {asm_q[ASM_W-aes_ctrl_pkg::WORD_W-1:0], bus_data};
		if (push) begin
			mem[wr_ptr].data <= {asm_q, bus_data};
			last_mem[wr_ptr] <= bus_tlast;
		end
	end

endmodule

`default_nettype wire

// ==== source/block_cipher.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_cipher #(
	parameter int NUM_ROUNDS = 8
) (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 start,
	input  wire                                 decrypt,
	input  wire  [aes_ctrl_pkg::KEY_W-1:0]      key,
	input  wire  [aes_ctrl_pkg::BLOCK_W-1:0]    in_blk,
	output logic                                done,
	output logic [aes_ctrl_pkg::BLOCK_W-1:0]    out_blk
);

	localparam int W  = aes_ctrl_pkg::BLOCK_W;
	localparam int RW = (NUM_ROUNDS > 1) ? $clog2(NUM_ROUNDS) : 1;

	logic [RW-1:0] cnt;
	logic          run;
	logic [RW-1:0] ridx;
	logic [W-1:0]  rk;
	logic [W-1:0]  src;
	logic [W-1:0]  nxt;

	function automatic logic [W-1:0] rotl(input logic [W-1:0] x, input int unsigned n);
		int unsigned s;
		s = n % W;
		return (x << s) | (x >> (W - s));
	endfunction

	function automatic logic [W-1:0] rotr(input logic [W-1:0] x, input int unsigned n);
		int unsigned s;
		s = n % W;
		return (x >> s) | (x << (W - s));
	endfunction

	// Decrypt walks the round keys backwards
	assign ridx = decrypt ? RW'(NUM_ROUNDS - 1) - cnt : cnt;
	assign rk   = rotl(key, aes_ctrl_pkg::RK_STEP * int'(ridx));
	assign src  = start ? in_blk : out_blk;

	always_comb begin
		if (decrypt)
			nxt = rotr(src - rk, aes_ctrl_pkg::ROT_BITS) ^ rk;
		else
			nxt = rotl(src ^ rk, aes_ctrl_pkg::ROT_BITS) + rk;
	end

	// Round 0 is applied on the start edge
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt  <= '0;
			run  <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= start ? (NUM_ROUNDS == 1) : (run && cnt == RW'(NUM_ROUNDS - 1));
			if (start) begin
				cnt <= (NUM_ROUNDS == 1) ? '0 : RW'(1);
				run <= (NUM_ROUNDS > 1);
			end else if (run) begin
				if (cnt == RW'(NUM_ROUNDS - 1)) begin
					cnt <= '0;
					run <= 1'b0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start || run)
			out_blk <= nxt;
	end

endmodule

`default_nettype wire

// ==== source/mode_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mode_sequencer (
	input  wire                                 clk,
	input  wire                                 reset,
	input  aes_ctrl_pkg::ctrl_block_u           in_blk,
	input  wire                                 in_last,
	input  wire                                 in_valid,
	output logic                                in_pop,
	output logic                                cipher_start,
	output logic                                cipher_decrypt,
	output logic [aes_ctrl_pkg::KEY_W-1:0]      cipher_key,
	output logic [aes_ctrl_pkg::BLOCK_W-1:0]    cipher_in_blk,
	input  wire                                 cipher_done,
	input  wire  [aes_ctrl_pkg::BLOCK_W-1:0]    cipher_out_blk,
	output logic                                out_push,
	output logic [aes_ctrl_pkg::BLOCK_W-1:0]    out_blk,
	output logic                                out_last,
	input  wire                                 out_full
);

	localparam logic [2:0] S_CMD  = 3'd0;
	localparam logic [2:0] S_KEY  = 3'd1;
	localparam logic [2:0] S_IV   = 3'd2;
	localparam logic [2:0] S_IDLE = 3'd3;
	localparam logic [2:0] S_BUSY = 3'd4;

	logic [2:0]                        state;
	logic                              cbc_q;
	logic                              last_q;
	logic [aes_ctrl_pkg::BLOCK_W-1:0]  chain;
	logic                              run_ok;

	// A push still in flight is not yet counted in out_full
	assign run_ok = in_valid && !out_full && !out_push;

	always_comb begin
		case (state)
			S_CMD, S_KEY, S_IV: in_pop = in_valid;
			S_IDLE:             in_pop = run_ok;
			default:            in_pop = 1'b0;
		endcase
	end

	// ============================================================
	// Control FSM
	// ============================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state          <= S_CMD;
			cipher_start   <= 1'b0;
			cipher_decrypt <= 1'b0;
			cbc_q          <= 1'b0;
			last_q         <= 1'b0;
			out_push       <= 1'b0;
		end else begin
			cipher_start <= 1'b0;
			out_push     <= 1'b0;
			case (state)
				S_CMD: if (in_valid) begin
					cipher_decrypt <= in_blk.cmd.word[aes_ctrl_pkg::CMD_DECRYPT_BIT];
					cbc_q          <= in_blk.cmd.word[aes_ctrl_pkg::CMD_CBC_BIT];
					state          <= S_KEY;
				end
				S_KEY: if (in_valid)
					state <= cbc_q ? S_IV : S_IDLE;
				// An IV alone can close the packet
				S_IV: if (in_valid)
					state <= in_last ? S_CMD : S_IDLE;
				S_IDLE: if (run_ok) begin
					cipher_start <= 1'b1;
					last_q       <= in_last;
					state        <= S_BUSY;
				end
				S_BUSY: if (cipher_done) begin
					out_push <= 1'b1;
					state    <= last_q ? S_CMD : S_IDLE;
				end
				default: state <= S_CMD;
			endcase
		end
	end

	// ============================================================
	// Key, chain and data path
	// ============================================================
	always_ff @(posedge clk) begin
		if (state == S_KEY && in_valid)
			cipher_key <= in_blk.data;
		if (state == S_IV && in_valid)
			chain <= in_blk.data;
		if (state == S_IDLE && run_ok)
			cipher_in_blk <= (cbc_q && !cipher_decrypt) ? in_blk.data ^ chain : in_blk.data;
		if (state == S_BUSY && cipher_done) begin
			out_last <= last_q;
			out_blk  <= (cbc_q && cipher_decrypt) ? cipher_out_blk ^ chain : cipher_out_blk;
			// Encrypt chains on ciphertext out, decrypt on ciphertext in
			if (cbc_q)
				chain <= cipher_decrypt ? cipher_in_blk : cipher_out_blk;
		end
	end

endmodule

`default_nettype wire

// ==== source/output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_stage #(
	parameter int OUT_FIFO_DEPTH = 4
) (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 push,
	input  wire  [aes_ctrl_pkg::BLOCK_W-1:0]    blk,
	input  wire                                 last,
	output logic                                full,
	output logic                                bus_tvalid,
	input  wire                                 bus_tready,
	output logic [aes_ctrl_pkg::WORD_W-1:0]     bus_tdata,
	output logic                                bus_tlast
);

	localparam int AW   = (OUT_FIFO_DEPTH > 1) ? $clog2(OUT_FIFO_DEPTH) : 1;
	localparam int CW   = $clog2(OUT_FIFO_DEPTH + 1);
	localparam int WC_W = $clog2(aes_ctrl_pkg::WORDS_PER_BLOCK);

	logic [aes_ctrl_pkg::BLOCK_W-1:0] mem [OUT_FIFO_DEPTH];
	logic                             last_mem [OUT_FIFO_DEPTH];
	logic [AW-1:0]                    wr_ptr;
	logic [AW-1:0]                    rd_ptr;
	logic [CW-1:0]                    count;
	logic [WC_W-1:0]                  widx;
	logic                             end_word;
	logic                             pop;

	assign full       = (count == CW'(OUT_FIFO_DEPTH));
	assign bus_tvalid = (count != '0);
	assign end_word   = (widx == WC_W'(aes_ctrl_pkg::WORDS_PER_BLOCK - 1));
	assign pop        = bus_tvalid && bus_tready && end_word;

	// Most significant word goes first
	assign bus_tdata = mem[rd_ptr][aes_ctrl_pkg::BLOCK_W - 1 - int'(widx) * aes_ctrl_pkg::WORD_W
		-: aes_ctrl_pkg::WORD_W];
	assign bus_tlast = last_mem[rd_ptr] && end_word;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			widx   <= '0;
		end else begin
			if (bus_tvalid && bus_tready)
				widx <= end_word ? '0 : widx + 1'b1;
			if (push)
				wr_ptr <= (wr_ptr == AW'(OUT_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == AW'(OUT_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr]      <= blk;
			last_mem[wr_ptr] <= last;
		end
	end

endmodule

`default_nettype wire

// ==== source/aes_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_controller #(
	parameter int IN_FIFO_DEPTH  = 4,
	parameter int OUT_FIFO_DEPTH = 4,
	parameter int NUM_ROUNDS     = 8
) (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 in_bus_data_wren,
	input  wire                                 in_bus_tlast,
	input  wire  [aes_ctrl_pkg::WORD_W-1:0]     in_bus_data,
	output logic                                controller_in_busy,
	output logic                                out_bus_tvalid,
	input  wire                                 out_bus_tready,
	output logic [aes_ctrl_pkg::WORD_W-1:0]     out_bus_tdata,
	output logic                                out_bus_tlast
);

	// ============================================================
	// Stage to stage wiring
	// ============================================================
	aes_ctrl_pkg::ctrl_block_u          in_blk;
	logic                               in_last;
	logic                               in_valid;
	logic                               in_pop;
	logic                               cipher_start;
	logic                               cipher_decrypt;
	logic [aes_ctrl_pkg::KEY_W-1:0]     cipher_key;
	logic [aes_ctrl_pkg::BLOCK_W-1:0]   cipher_in_blk;
	logic                               cipher_done;
	logic [aes_ctrl_pkg::BLOCK_W-1:0]   cipher_out_blk;
	logic                               out_push;
	logic [aes_ctrl_pkg::BLOCK_W-1:0]   out_blk;
	logic                               out_last;
	logic                               out_full;

	input_stage #(.IN_FIFO_DEPTH(IN_FIFO_DEPTH)) input_stage0 (
		.clk(clk), .reset(reset),
		.bus_data(in_bus_data), .bus_data_wren(in_bus_data_wren), .bus_tlast(in_bus_tlast),
		.busy(controller_in_busy),
		.in_blk(in_blk), .in_last(in_last), .in_valid(in_valid), .in_pop(in_pop)
	);

	mode_sequencer mode_sequencer0 (
		.clk(clk), .reset(reset),
		.in_blk(in_blk), .in_last(in_last), .in_valid(in_valid), .in_pop(in_pop),
		.cipher_start(cipher_start), .cipher_decrypt(cipher_decrypt),
		.cipher_key(cipher_key), .cipher_in_blk(cipher_in_blk),
		.cipher_done(cipher_done), .cipher_out_blk(cipher_out_blk),
		.out_push(out_push), .out_blk(out_blk), .out_last(out_last), .out_full(out_full)
	);

	block_cipher #(.NUM_ROUNDS(NUM_ROUNDS)) block_cipher0 (
		.clk(clk), .reset(reset),
		.start(cipher_start), .decrypt(cipher_decrypt), .key(cipher_key),
		.in_blk(cipher_in_blk), .done(cipher_done), .out_blk(cipher_out_blk)
	);

	output_stage #(.OUT_FIFO_DEPTH(OUT_FIFO_DEPTH)) output_stage0 (
		.clk(clk), .reset(reset),
		.push(out_push), .blk(out_blk), .last(out_last), .full(out_full),
		.bus_tvalid(out_bus_tvalid), .bus_tready(out_bus_tready),
		.bus_tdata(out_bus_tdata), .bus_tlast(out_bus_tlast)
	);

endmodule

`default_nettype wire

// ==== tests/aes_controller_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_controller_assert (
	input wire        clk,
	input wire        reset,
	input wire        in_bus_data_wren,
	input wire        controller_in_busy,
	input wire        out_bus_tvalid,
	input wire        out_bus_tready,
	input wire [31:0] out_bus_tdata,
	input wire        out_bus_tlast
);

	// Stalled word holds its data and last flag
	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		(out_bus_tvalid && !out_bus_tready) |=> ($stable(out_bus_tdata) && $stable(out_bus_tlast)))
		else $error("Output word changed while stalled");

	a_valid_kept: assert property (@(posedge clk) disable iff (reset)
		(out_bus_tvalid && !out_bus_tready) |=> out_bus_tvalid)
		else $error("Output valid dropped without a handshake");

	a_busy_honored: assert property (@(posedge clk) disable iff (reset)
		!(in_bus_data_wren && controller_in_busy))
		else $error("Input word written while the controller was busy");

endmodule

bind aes_controller aes_controller_assert aes_controller_assert0 (
	.clk(clk), .reset(reset),
	.in_bus_data_wren(in_bus_data_wren), .controller_in_busy(controller_in_busy),
	.out_bus_tvalid(out_bus_tvalid), .out_bus_tready(out_bus_tready),
	.out_bus_tdata(out_bus_tdata), .out_bus_tlast(out_bus_tlast)
);

`default_nettype wire

// ==== tests/tb_aes_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_aes_controller;

	localparam int ROUNDS = 8;
	// Words sent over all tests including command, key and IV blocks
	localparam int TOTAL_WORDS  = 180;
	localparam int LIMIT_CYCLES = TOTAL_WORDS * 40 + 2000;

	logic        clk;
	logic        reset;
	logic        in_bus_data_wren;
	logic        in_bus_tlast;
	logic [31:0] in_bus_data;
	logic        controller_in_busy;
	logic        out_bus_tvalid;
	logic        out_bus_tready;
	logic [31:0] out_bus_tdata;
	logic        out_bus_tlast;

	logic [31:0]  exp_data [$];
	logic         exp_last [$];
	string        exp_name [$];
	logic [127:0] pay [$];
	logic [127:0] res [$];
	logic [127:0] pt_a [$];
	logic [127:0] pt_b [$];
	logic [127:0] key;
	logic [127:0] iv;
	logic [31:0]  exp_word;
	logic         exp_flag;
	string        exp_tag;
	bit           ready_random;
	int           busy_count;
	int           busy_before;
	int           data_errs;
	int           last_errs;
	int           extra_errs;
	int           check_errs;

	aes_controller dut0 (
		.clk(clk), .reset(reset),
		.in_bus_data_wren(in_bus_data_wren), .in_bus_tlast(in_bus_tlast),
		.in_bus_data(in_bus_data), .controller_in_busy(controller_in_busy),
		.out_bus_tvalid(out_bus_tvalid), .out_bus_tready(out_bus_tready),
		.out_bus_tdata(out_bus_tdata), .out_bus_tlast(out_bus_tlast)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ============================================================
	// Reference model
	// ============================================================
	function automatic logic [127:0] rot_left(input logic [127:0] x, input int n);
		logic [255:0] d;
		d = {x, x} << (n % 128);
		return d[255:128];
	endfunction

	function automatic logic [127:0] rot_right(input logic [127:0] x, input int n);
		return rot_left(x, 128 - n % 128);
	endfunction

	function automatic logic [127:0] enc_ref(input logic [127:0] pt, input logic [127:0] k);
		logic [127:0] s;
		logic [127:0] rk;
		s = pt;
		for (int r = 0; r < ROUNDS; r++) begin
			rk = rot_left(k, aes_ctrl_pkg::RK_STEP * r);
			s  = rot_left(s ^ rk, aes_ctrl_pkg::ROT_BITS) + rk;
		end
		return s;
	endfunction

	function automatic logic [127:0] dec_ref(input logic [127:0] ct, input logic [127:0] k);
		logic [127:0] s;
		logic [127:0] rk;
		s = ct;
		for (int r = ROUNDS - 1; r >= 0; r--) begin
			rk = rot_left(k, aes_ctrl_pkg::RK_STEP * r);
			s  = rot_right(s - rk, aes_ctrl_pkg::ROT_BITS) ^ rk;
		end
		return s;
	endfunction

	task automatic expect_block(input logic [127:0] blk, input logic last, input string name);
		for (int w = 0; w < 4; w++) begin
			exp_data.push_back(blk[127 - 32 * w -: 32]);
			exp_last.push_back(last && w == 3);
			exp_name.push_back(name);
		end
	endtask

	// Model output of one packet from pay and keep the results in res
	task automatic expect_packet(input bit dec, input bit cbc, input logic [127:0] k,
		input logic [127:0] v, input string name);
		logic [127:0] chain;
		logic [127:0] o;
		chain = v;
		res.delete();
		foreach (pay[i]) begin
			if (!cbc) begin
				o = dec ? dec_ref(pay[i], k) : enc_ref(pay[i], k);
			end else if (!dec) begin
				o     = enc_ref(pay[i] ^ chain, k);
				chain = o;
			end else begin
				o     = dec_ref(pay[i], k) ^ chain;
				chain = pay[i];
			end
			res.push_back(o);
			expect_block(o, i == pay.size() - 1, name);
		end
	endtask

	// ============================================================
	// Input bus driver
	// ============================================================
	task automatic send_word(input logic [31:0] w, input logic l);
		@(negedge clk);
		while (controller_in_busy) begin
			in_bus_data_wren = 1'b0;
			@(negedge clk);
		end
		in_bus_data      = w;
		in_bus_tlast     = l;
		in_bus_data_wren = 1'b1;
	endtask

	task automatic send_block(input logic [127:0] blk, input logic last);
		for (int w = 0; w < 4; w++)
			send_word(blk[127 - 32 * w -: 32], last && w == 3);
	endtask

	task automatic send_packet(input bit dec, input bit cbc, input logic [127:0] k,
		input logic [127:0] v);
		logic [31:0] cmd;
		cmd = 32'h0;
		cmd[aes_ctrl_pkg::CMD_CBC_BIT]     = cbc;
		cmd[aes_ctrl_pkg::CMD_DECRYPT_BIT] = dec;
		// Reserved command bits carry noise
		send_block({$urandom(), $urandom(), $urandom(), cmd}, 1'b0);
		send_block(k, 1'b0);
		if (cbc)
			send_block(v, 1'b0);
		foreach (pay[i])
			send_block(pay[i], i == pay.size() - 1);
	endtask

	task automatic bus_idle();
		@(negedge clk);
		in_bus_data_wren = 1'b0;
		in_bus_tlast     = 1'b0;
	endtask

	task automatic drain();
		while (exp_data.size() != 0)
			@(posedge clk);
	endtask

	function automatic logic [127:0] rand_block();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// Output ready is random at about 30% during the back-pressure test
	initial begin
		out_bus_tready = 1'b1;
		forever begin
			@(negedge clk);
			out_bus_tready = ready_random ? (($urandom() % 100) < 30) : 1'b1;
		end
	end

	always @(posedge clk) begin
		if (controller_in_busy)
			busy_count++;
	end

	// ============================================================
	// Output compare
	// ============================================================
	always @(posedge clk) begin
		if (!reset && out_bus_tvalid && out_bus_tready) begin
			assert (exp_data.size() != 0) else begin
				$display("Output word %h arrived when no word was expected", out_bus_tdata);
				extra_errs++;
			end
			if (exp_data.size() != 0) begin
				exp_word = exp_data.pop_front();
				exp_flag = exp_last.pop_front();
				exp_tag  = exp_name.pop_front();
				assert (out_bus_tdata === exp_word) else begin
					$display("ERR %s: expected %h, got %h", exp_tag, exp_word, out_bus_tdata);
					data_errs++;
				end
				assert (out_bus_tlast === exp_flag) else begin
					$display("ERR %s tlast: expected %0b, got %0b", exp_tag, exp_flag,
						out_bus_tlast);
					last_errs++;
				end
			end
		end
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles with %0d words still expected", LIMIT_CYCLES,
			exp_data.size());
		$display("Regression failed");
		$finish;
	end

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		void'($urandom(32'h231e));
		reset            = 1'b1;
		in_bus_data_wren = 1'b0;
		in_bus_tlast     = 1'b0;
		in_bus_data      = 32'h0;
		ready_random     = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// ECB encrypt then decrypt of its ciphertext
		key = rand_block();
		pay.delete();
		repeat (6) pay.push_back(rand_block());
		pt_a = pay;
		expect_packet(1'b0, 1'b0, key, 128'h0, "ecb_enc");
		send_packet(1'b0, 1'b0, key, 128'h0);
		pay = res;
		foreach (pt_a[i])
			expect_block(pt_a[i], i == pt_a.size() - 1, "ecb_dec");
		send_packet(1'b1, 1'b0, key, 128'h0);
		bus_idle();
		drain();

		// CBC encrypt and decrypt sent back to back
		key = rand_block();
		iv  = rand_block();
		pay.delete();
		repeat (5) pay.push_back(rand_block());
		pt_b = pay;
		expect_packet(1'b0, 1'b1, key, iv, "cbc_enc");
		send_packet(1'b0, 1'b1, key, iv);
		pay = res;
		foreach (pt_b[i])
			expect_block(pt_b[i], i == pt_b.size() - 1, "cbc_dec");
		send_packet(1'b1, 1'b1, key, iv);
		bus_idle();
		drain();

		// Back-pressure on the output bus
		ready_random = 1'b1;
		busy_before  = busy_count;
		key = rand_block();
		iv  = rand_block();
		pay.delete();
		repeat (10) pay.push_back(rand_block());
		expect_packet(1'b1, 1'b1, key, iv, "backpressure");
		send_packet(1'b1, 1'b1, key, iv);
		bus_idle();
		drain();
		ready_random = 1'b0;
		assert (busy_count != busy_before) else begin
			$display("Input busy never rose while the output bus was stalled");
			check_errs++;
		end

		repeat (20) @(posedge clk);
		$display("Errors: data %0d, last %0d, extra %0d, other %0d", data_errs, last_errs,
			extra_errs, check_errs);
		if (data_errs + last_errs + extra_errs + check_errs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
source/aes_ctrl_pkg.sv
source/input_stage.sv
source/block_cipher.sv
source/mode_sequencer.sv
source/output_stage.sv
source/aes_controller.sv
tests/aes_controller_assert.sv
tests/tb_aes_controller.sv

// ==== Makefile ====
TOP = tb_aes_controller

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f src.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
